//--- bench/exec_cases.txt
# kind pc instr npc rd wen data, all hex; R retires in this order
# D is a wrong-path entry after a redirect, decode drops it
R 00000100 12300093 00000104 01 1 00000123
R 00000104 ffb08113 00000108 02 1 0000011e
R 00000108 002081b3 0000010c 03 1 00000241
R 0000010c 40118233 00000110 04 1 0000011e
R 00000110 800012b7 00000114 05 1 80001000
R 00000114 4042d313 00000118 06 1 f8000100
R 00000118 0042d393 0000011c 07 1 08000100
R 0000011c 00734433 00000120 08 1 f0000000
R 00000120 001424b3 00000124 09 1 00000001
R 00000124 00143533 00000128 0a 1 00000000
R 00000128 00809593 0000012c 0b 1 00012300
R 0000012c 00001617 00000130 0c 1 0000112c
R 00000130 00b0e6b3 00000134 0d 1 00012323
R 00000134 0f06f713 00000138 0e 1 00000020
# beq x2, x4 taken to 0x148
R 00000138 00410863 00000148 00 0 00000000
D 0000013c 00100793 0 0 0 0
D 00000140 00200793 0 0 0 0
# bne x1, x1 not taken
R 00000148 fc1090e3 0000014c 00 0 00000000
# jal x16 to 0x158
R 0000014c 00c0086f 00000158 10 1 00000150
D 00000150 00300793 0 0 0 0
# jalr x17 to (x16 + 0x21) with bit 0 cleared
R 00000158 021808e7 00000170 11 1 0000015c
D 0000015c 00500793 0 0 0 0
R 00000170 01088933 00000174 12 1 000002ac
# blt x9, x0 not taken, bgeu x8, x1 taken
R 00000174 0004c463 00000178 00 0 00000000
R 00000178 00147663 00000184 00 0 00000000
D 0000017c 00600793 0 0 0 0
D 00000180 00700793 0 0 0 0
R 00000184 7ff90993 00000188 13 1 00000aab
R 00000188 40945a33 0000018c 14 1 f8000000
R 0000018c 00999ab3 00000190 15 1 00001556
# write to x0 retires without a write
R 00000190 00508013 00000194 00 0 00000000
R 00000194 01500b33 00000198 16 1 00001556

//--- bench/rv_exec_cluster_tb.sv
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_exec_cluster_tb;
  import rv_isa_pkg::*;

  localparam int CYCLES_PER_RECORD = 40;

  logic      clock;
  logic      reset;
  logic      instr_valid;
  instr_t    instr;
  word_t     instr_pc;
  logic      instr_credit;
  logic      retire_credit;
  logic      retire_valid;
  word_t     retire_pc;
  word_t     retire_npc;
  reg_addr_t retire_rd;
  logic      retire_wen;
  word_t     retire_data;

  // input stream, wrong-path entries included.
  word_t     in_pc [$];
  instr_t    in_instr [$];
  // retires in program order.
  word_t     exp_pc [$];
  word_t     exp_npc [$];
  reg_addr_t exp_rd [$];
  logic      exp_wen [$];
  word_t     exp_data [$];

  integer seed;
  int     errors;
  int     cycles;
  int     limit;
  int     sent;
  int     retired;
  int     icredits;
  int     rcredits;
  logic   grant;
  logic   timed_out;

  rv_exec_cluster rv_exec_cluster_i (.*);

  always #5 clock = ~clock;

  ////////////////////////////////////////////////////////////
  // case file
  ////////////////////////////////////////////////////////////

  task automatic load_cases();
    integer           fd;
    integer           n;
    logic [8*160-1:0] line;
    logic [7:0]       tag;
    word_t            pc;
    instr_t           word;
    word_t            npc;
    logic [7:0]       rd;
    logic [7:0]       wen;
    word_t            data;
    fd = $fopen("bench/exec_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open bench/exec_cases.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      n = $sscanf(line, "%s %h %h %h %h %h %h", tag, pc, word, npc, rd, wen, data);
      if (n == 7 && (tag == "R" || tag == "D")) begin
        in_pc.push_back(pc);
        in_instr.push_back(word);
        if (tag == "R") begin
          exp_pc.push_back(pc);
          exp_npc.push_back(npc);
          exp_rd.push_back(rd[4:0]);
          exp_wen.push_back(wen[0]);
          exp_data.push_back(data);
        end
      end else if (n > 0 && tag != "#") begin
        $display("malformed line in case file: %0s", line);
        errors++;
      end
    end
    $fclose(fd);
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  task automatic check_retire();
    if (retired >= exp_pc.size()) begin
      $display("unexpected retire of pc %h after the last expected record", retire_pc);
      errors++;
      return;
    end
    if (retire_pc !== exp_pc[retired]) begin
      $display("CHECK FAILED retire_pc got %h expected %h", retire_pc, exp_pc[retired]);
      errors++;
    end
    if (retire_npc !== exp_npc[retired]) begin
      $display("CHECK FAILED retire_npc got %h expected %h at pc %h",
               retire_npc, exp_npc[retired], exp_pc[retired]);
      errors++;
    end
    if (retire_wen !== exp_wen[retired]) begin
      $display("CHECK FAILED retire_wen got %h expected %h at pc %h",
               retire_wen, exp_wen[retired], exp_pc[retired]);
      errors++;
    end
    // rd and data only mean something for a write.
    if (exp_wen[retired]) begin
      if (retire_rd !== exp_rd[retired]) begin
        $display("CHECK FAILED retire_rd got %h expected %h at pc %h",
                 retire_rd, exp_rd[retired], exp_pc[retired]);
        errors++;
      end
      if (retire_data !== exp_data[retired]) begin
        $display("CHECK FAILED retire_data got %h expected %h at pc %h",
                 retire_data, exp_data[retired], exp_pc[retired]);
        errors++;
      end
    end
    retired++;
  endtask

  // one clock: drive after the edge, sample mid-cycle.
  task automatic step();
    @(posedge clock);
    #1;
    cycles++;
    instr_valid = 1'b0;
    if (sent < in_pc.size() && icredits > 0) begin
      instr_valid = 1'b1;
      instr       = in_instr[sent];
      instr_pc    = in_pc[sent];
      sent++;
      icredits--;
    end
    grant = (($random(seed) & 7) < 3) && (rcredits < `RETIRE_CREDITS);
    retire_credit = grant;
    @(negedge clock);
    if (instr_credit) begin
      icredits++;
      if (icredits > `IBUF_DEPTH) begin
        $display("more instruction credits came back than were sent");
        errors++;
      end
    end
    if (retire_valid) begin
      if (rcredits == 0) begin
        $display("retire_valid raised while no retire credit was granted");
        errors++;
      end else begin
        rcredits--;
      end
      check_retire();
    end
    if (grant) begin
      rcredits++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    instr_valid   = 1'b0;
    instr         = '0;
    instr_pc      = '0;
    retire_credit = 1'b0;
    seed          = 32'h91e3_4aab;
    errors        = 0;
    cycles        = 0;
    sent          = 0;
    retired       = 0;
    icredits      = `IBUF_DEPTH;
    rcredits      = 0;
    grant         = 1'b0;
    timed_out     = 1'b0;
    load_cases();
    limit = CYCLES_PER_RECORD * in_pc.size();

    repeat (8) @(posedge clock);
    #1;
    if (instr_credit !== 1'b0 || retire_valid !== 1'b0) begin
      $display("instr_credit or retire_valid not low during reset");
      errors++;
    end
    reset = 1'b0;

    while (!timed_out && !(retired == exp_pc.size() && sent == in_pc.size() &&
                           icredits == `IBUF_DEPTH)) begin
      step();
      if (cycles >= limit) begin
        $display("timeout after %0d cycles with %0d of %0d records retired",
                 cycles, retired, exp_pc.size());
        errors++;
        timed_out = 1'b1;
      end
    end
    // late retires would be wrong-path leaks.
    if (!timed_out) begin
      repeat (10) step();
    end

    $display("errors: %0d, retired %0d of %0d", errors, retired, exp_pc.size());
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_alu.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_result.sv
verilog/rv_exec_cluster.sv
bench/rv_exec_cluster_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execution cluster testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module rv_exec_cluster_tb -Mdir obj_dir

out=$(./obj_dir/Vrv_exec_cluster_tb)
echo "$out"
echo "$out" | grep -q "^=== PASS ===$"

//--- verilog/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_isa_pkg::alu_op_t op,
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  output rv_isa_pkg::word_t   result
);
  import rv_isa_pkg::*;

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b[4:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  always_comb begin
    result = '0;
    case (op)
      ALU_ADD:  result = a + b;
      ALU_SUB:  result = a - b;
      ALU_SLL:  result = a << shamt;
      ALU_SLT:  result[0] = lt_s;
      ALU_SLTU: result[0] = lt_u;
      ALU_XOR:  result = a ^ b;
      ALU_SRL:  result = a >> shamt;
      ALU_SRA:  result = word_t'($signed(a) >>> shamt);
      ALU_OR:   result = a | b;
      ALU_AND:  result = a & b;
      // compares for branches.
      ALU_EQ:   result[0] = eq;
      ALU_NE:   result[0] = !eq;
      ALU_LT:   result[0] = lt_s;
      ALU_GE:   result[0] = !lt_s;
      ALU_LTU:  result[0] = lt_u;
      ALU_GEU:  result[0] = !lt_u;
    endcase
  end

endmodule

//--- verilog/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

////////////////////////////////////////////////////////////
// core sizing
////////////////////////////////////////////////////////////

// data and pc width.
`define XLEN 32

// architectural registers, x0 included.
`define NUM_REGS 32

// decode input buffer entries, also the instruction credits after reset.
`define IBUF_DEPTH 4

// most retire credits the result stage can hold.
`define RETIRE_CREDITS 4

`endif

//--- verilog/rv_decode.sv
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_decode (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  instr_valid,
  input  rv_isa_pkg::instr_t    instr,
  input  rv_isa_pkg::word_t     instr_pc,
  output logic                  instr_credit,
  output rv_isa_pkg::reg_addr_t rs1_addr,
  output rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::word_t     rs1_rdata,
  input  rv_isa_pkg::word_t     rs2_rdata,
  input  logic                  ex_fwd_valid,
  input  rv_isa_pkg::reg_addr_t ex_fwd_rd,
  input  rv_isa_pkg::word_t     ex_fwd_data,
  input  logic                  rs_fwd_valid,
  input  rv_isa_pkg::reg_addr_t rs_fwd_rd,
  input  rv_isa_pkg::word_t     rs_fwd_data,
  input  logic                  redirect,
  input  rv_isa_pkg::word_t     redirect_pc,
  input  logic                  stall,
  output logic                  id_valid,
  output rv_isa_pkg::word_t     id_pc,
  output rv_isa_pkg::alu_op_t   id_op,
  output logic                  id_op1_pc,
  output logic                  id_op2_imm,
  output rv_isa_pkg::word_t     id_imm,
  output rv_isa_pkg::word_t     id_rs1_data,
  output rv_isa_pkg::word_t     id_rs2_data,
  output rv_isa_pkg::reg_addr_t id_rd,
  output logic                  id_wen,
  output rv_isa_pkg::npc_sel_t  id_npc_sel,
  output rv_isa_pkg::wsel_t     id_wsel
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  instr_t    ibuf_instr [`IBUF_DEPTH];
  word_t     ibuf_pc    [`IBUF_DEPTH];
  ibuf_ptr_t wr_ptr;
  ibuf_ptr_t rd_ptr;
  logic      empty;
  logic      full;
  logic      pop;
  logic      issue;
  logic      exp_known;
  word_t     exp_pc;
  word_t     want_pc;
  instr_t    head;
  word_t     head_pc;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;
  word_t      imm_i;
  word_t      imm_u;
  word_t      imm_j;
  word_t      imm_b;
  alu_op_t    arith_op;
  alu_op_t    branch_op;
  alu_op_t    d_op;
  logic       d_op1_pc;
  logic       d_op2_imm;
  logic       d_wen;
  word_t      d_imm;
  npc_sel_t   d_npc;
  wsel_t      d_wsel;

  ////////////////////////////////////////////////////////////
  // input buffer and path filter
  ////////////////////////////////////////////////////////////

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[IBUF_AW-1:0] == rd_ptr[IBUF_AW-1:0]) &&
                 (wr_ptr[IBUF_AW] != rd_ptr[IBUF_AW]);
  assign head    = ibuf_instr[rd_ptr[IBUF_AW-1:0]];
  assign head_pc = ibuf_pc[rd_ptr[IBUF_AW-1:0]];
  assign pop     = !empty && !stall;

  // a redirect names the pc of the entry popped in the same cycle.
  assign want_pc = redirect ? redirect_pc : exp_pc;
  assign issue   = pop && (!exp_known || head_pc == want_pc);

  always_ff @(posedge clock) begin
    if (instr_valid) begin
      ibuf_instr[wr_ptr[IBUF_AW-1:0]] <= instr;
      ibuf_pc[wr_ptr[IBUF_AW-1:0]]    <= instr_pc;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      instr_credit <= 1'b0;
      exp_known    <= 1'b0;
      exp_pc       <= '0;
    end else begin
      if (instr_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // one credit per consumed entry, issued or dropped.
      instr_credit <= pop;
      if (issue) begin
        exp_pc    <= head_pc + 32'd4;
        exp_known <= 1'b1;
      end else if (redirect) begin
        exp_pc <= redirect_pc;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // field decode
  ////////////////////////////////////////////////////////////

  assign opcode = head[6:0];
  assign funct3 = head[14:12];
  assign alt    = head[30];
  assign imm_i  = {{20{head[31]}}, head[31:20]};
  assign imm_u  = {head[31:12], 12'b0};
  assign imm_j  = {{12{head[31]}}, head[19:12], head[20], head[30:21], 1'b0};
  assign imm_b  = {{20{head[31]}}, head[7], head[30:25], head[11:8], 1'b0};

  // lui adds its immediate to x0.
  assign rs1_addr = (opcode == OPC_LUI) ? '0 : head[19:15];
  assign rs2_addr = head[24:20];

  always_comb begin
    case (funct3)
      3'b000:  arith_op = (alt && opcode == OPC_OP) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  branch_op = ALU_EQ;
      3'b001:  branch_op = ALU_NE;
      3'b100:  branch_op = ALU_LT;
      3'b101:  branch_op = ALU_GE;
      3'b110:  branch_op = ALU_LTU;
      default: branch_op = ALU_GEU;
    endcase
  end

  always_comb begin
    d_op      = ALU_ADD;
    d_op1_pc  = 1'b0;
    d_op2_imm = 1'b1;
    d_imm     = imm_i;
    d_wen     = 1'b1;
    d_npc     = NPC_SEQ;
    d_wsel    = WSEL_ALU;
    case (opcode)
      OPC_OP: begin
        d_op      = arith_op;
        d_op2_imm = 1'b0;
      end
      OPC_OP_IMM: d_op = arith_op;
      OPC_LUI:    d_imm = imm_u;
      OPC_AUIPC: begin
        d_imm    = imm_u;
        d_op1_pc = 1'b1;
        d_wsel   = WSEL_PCIMM;
      end
      OPC_JAL: begin
        d_imm    = imm_j;
        d_op1_pc = 1'b1;
        d_npc    = NPC_JAL;
        d_wsel   = WSEL_LINK;
      end
      OPC_JALR: begin
        d_npc  = NPC_JALR;
        d_wsel = WSEL_LINK;
      end
      OPC_BRANCH: begin
        d_op      = branch_op;
        d_op2_imm = 1'b0;
        d_imm     = imm_b;
        d_wen     = 1'b0;
        d_npc     = NPC_BRANCH;
      end
      // unknown opcode, no write.
      default: d_wen = 1'b0;
    endcase
  end

  // execute first, then result, then the register file.
  function automatic word_t operand(input reg_addr_t addr, input word_t rdata);
    if (addr == '0) begin
      return rdata;
    end
    if (ex_fwd_valid && ex_fwd_rd == addr) begin
      return ex_fwd_data;
    end
    if (rs_fwd_valid && rs_fwd_rd == addr) begin
      return rs_fwd_data;
    end
    return rdata;
  endfunction

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (!stall) begin
      id_valid <= issue;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      id_pc       <= head_pc;
      id_op       <= d_op;
      id_op1_pc   <= d_op1_pc;
      id_op2_imm  <= d_op2_imm;
      id_imm      <= d_imm;
      id_rs1_data <= operand(rs1_addr, rs1_rdata);
      id_rs2_data <= operand(rs2_addr, rs2_rdata);
      id_rd       <= head[11:7];
      id_wen      <= d_wen && (head[11:7] != '0);
      id_npc_sel  <= d_npc;
      id_wsel     <= d_wsel;
    end
  end

  // the source only sends while it holds a credit.
  a_no_overflow: assert property (@(posedge clock) disable iff (reset)
    instr_valid |-> !full)
    else $error("instruction arrived with the input buffer full");

endmodule

//--- verilog/rv_exec_cluster.sv
`timescale 1ns/100ps

module rv_exec_cluster (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  instr_valid,
  input  rv_isa_pkg::instr_t    instr,
  input  rv_isa_pkg::word_t     instr_pc,
  output logic                  instr_credit,
  input  logic                  retire_credit,
  output logic                  retire_valid,
  output rv_isa_pkg::word_t     retire_pc,
  output rv_isa_pkg::word_t     retire_npc,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output logic                  retire_wen,
  output rv_isa_pkg::word_t     retire_data
);
  import rv_isa_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_rdata;
  word_t     rs2_rdata;
  logic      ex_fwd_valid;
  reg_addr_t ex_fwd_rd;
  word_t     ex_fwd_data;
  logic      rs_fwd_valid;
  reg_addr_t rs_fwd_rd;
  word_t     rs_fwd_data;
  logic      redirect;
  word_t     redirect_pc;
  logic      stall;

  // decode to execute.
  logic      id_valid;
  word_t     id_pc;
  alu_op_t   id_op;
  logic      id_op1_pc;
  logic      id_op2_imm;
  word_t     id_imm;
  word_t     id_rs1_data;
  word_t     id_rs2_data;
  reg_addr_t id_rd;
  logic      id_wen;
  npc_sel_t  id_npc_sel;
  wsel_t     id_wsel;

  // execute to result.
  logic      ex_valid;
  word_t     ex_pc;
  word_t     ex_npc;
  reg_addr_t ex_rd;
  logic      ex_wen;
  word_t     ex_wdata;

  rv_decode  decode_i  (.*);
  rv_execute execute_i (.*);
  rv_result  result_i  (.*);

endmodule

//--- verilog/rv_execute.sv
`timescale 1ns/100ps

module rv_execute (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  stall,
  input  logic                  id_valid,
  input  rv_isa_pkg::word_t     id_pc,
  input  rv_isa_pkg::alu_op_t   id_op,
  input  logic                  id_op1_pc,
  input  logic                  id_op2_imm,
  input  rv_isa_pkg::word_t     id_imm,
  input  rv_isa_pkg::word_t     id_rs1_data,
  input  rv_isa_pkg::word_t     id_rs2_data,
  input  rv_isa_pkg::reg_addr_t id_rd,
  input  logic                  id_wen,
  input  rv_isa_pkg::npc_sel_t  id_npc_sel,
  input  rv_isa_pkg::wsel_t     id_wsel,
  output logic                  ex_fwd_valid,
  output rv_isa_pkg::reg_addr_t ex_fwd_rd,
  output rv_isa_pkg::word_t     ex_fwd_data,
  output logic                  redirect,
  output rv_isa_pkg::word_t     redirect_pc,
  output logic                  ex_valid,
  output rv_isa_pkg::word_t     ex_pc,
  output rv_isa_pkg::word_t     ex_npc,
  output rv_isa_pkg::reg_addr_t ex_rd,
  output logic                  ex_wen,
  output rv_isa_pkg::word_t     ex_wdata
);
  import rv_isa_pkg::*;

  // decode's output register is the stage register here.
  word_t op_a;
  word_t op_b;
  word_t alu_out;
  word_t pc_plus4;
  word_t pc_plus_imm;
  word_t npc;
  word_t wdata;

  ////////////////////////////////////////////////////////////
  // operands and alu
  ////////////////////////////////////////////////////////////

  assign op_a = id_op1_pc ? id_pc : id_rs1_data;
  assign op_b = id_op2_imm ? id_imm : id_rs2_data;

  rv_alu alu_i (
    .op     (id_op),
    .a      (op_a),
    .b      (op_b),
    .result (alu_out)
  );

  assign pc_plus4    = id_pc + 32'd4;
  assign pc_plus_imm = id_pc + id_imm;

  ////////////////////////////////////////////////////////////
  // next pc and write value
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (id_npc_sel)
      NPC_SEQ:    npc = pc_plus4;
      NPC_JAL:    npc = pc_plus_imm;
      NPC_JALR:   npc = alu_out & ~word_t'(1);
      NPC_BRANCH: npc = alu_out[0] ? pc_plus_imm : pc_plus4;
    endcase
  end

  always_comb begin
    case (id_wsel)
      WSEL_LINK:  wdata = pc_plus4;
      WSEL_PCIMM: wdata = pc_plus_imm;
      default:    wdata = alu_out;
    endcase
  end

  assign ex_valid = id_valid;
  assign ex_pc    = id_pc;
  assign ex_npc   = npc;
  assign ex_rd    = id_rd;
  assign ex_wen   = id_wen;
  assign ex_wdata = wdata;

  assign ex_fwd_valid = id_valid && id_wen;
  assign ex_fwd_rd    = id_rd;
  assign ex_fwd_data  = wdata;

  // held instructions redirect once, when they move on.
  assign redirect    = id_valid && !stall && (npc != pc_plus4);
  assign redirect_pc = npc;

  a_redirect_aligned: assert property (@(posedge clock) disable iff (reset)
    redirect |-> redirect_pc[1:0] == 2'b00)
    else $error("misaligned redirect target %h", redirect_pc);

  // decode keeps its register while stalled.
  a_stall_holds: assert property (@(posedge clock) disable iff (reset)
    id_valid && stall |=> id_valid && $stable(id_pc))
    else $error("execute input changed during a stall");

endmodule

//--- verilog/rv_isa_pkg.sv
`include "rv_core_defs.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [31:0]      instr_t;
  typedef logic [4:0]       reg_addr_t;
  typedef logic [3:0]       alu_op_t;
  typedef logic [1:0]       npc_sel_t;
  typedef logic [1:0]       wsel_t;

  // major opcodes of the supported groups.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRL  = 4'd6;
  localparam alu_op_t ALU_SRA  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  // branch compares, result in bit 0.
  localparam alu_op_t ALU_EQ   = 4'd10;
  localparam alu_op_t ALU_NE   = 4'd11;
  localparam alu_op_t ALU_LT   = 4'd12;
  localparam alu_op_t ALU_GE   = 4'd13;
  localparam alu_op_t ALU_LTU  = 4'd14;
  localparam alu_op_t ALU_GEU  = 4'd15;

  localparam npc_sel_t NPC_SEQ    = 2'd0;
  localparam npc_sel_t NPC_JAL    = 2'd1;
  localparam npc_sel_t NPC_JALR   = 2'd2;
  localparam npc_sel_t NPC_BRANCH = 2'd3;

  localparam wsel_t WSEL_ALU   = 2'd0;
  localparam wsel_t WSEL_LINK  = 2'd1;
  localparam wsel_t WSEL_PCIMM = 2'd2;

endpackage

//--- verilog/rv_pipe_pkg.sv
`include "rv_core_defs.svh"

package rv_pipe_pkg;

  ////////////////////////////////////////////////////////////
  // credit counts
  ////////////////////////////////////////////////////////////

  localparam int CREDIT_MAX = (`IBUF_DEPTH > `RETIRE_CREDITS) ?
                              `IBUF_DEPTH : `RETIRE_CREDITS;

  typedef logic [$clog2(CREDIT_MAX+1)-1:0] credit_t;

  ////////////////////////////////////////////////////////////
  // input buffer pointers
  ////////////////////////////////////////////////////////////

  localparam int IBUF_AW = $clog2(`IBUF_DEPTH);

  // top bit is the wrap bit.
  typedef logic [IBUF_AW:0] ibuf_ptr_t;

endpackage

//--- verilog/rv_result.sv
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_result (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  ex_valid,
  input  rv_isa_pkg::word_t     ex_pc,
  input  rv_isa_pkg::word_t     ex_npc,
  input  rv_isa_pkg::reg_addr_t ex_rd,
  input  logic                  ex_wen,
  input  rv_isa_pkg::word_t     ex_wdata,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  output rv_isa_pkg::word_t     rs1_rdata,
  output rv_isa_pkg::word_t     rs2_rdata,
  output logic                  rs_fwd_valid,
  output rv_isa_pkg::reg_addr_t rs_fwd_rd,
  output rv_isa_pkg::word_t     rs_fwd_data,
  output logic                  stall,
  input  logic                  retire_credit,
  output logic                  retire_valid,
  output rv_isa_pkg::word_t     retire_pc,
  output rv_isa_pkg::word_t     retire_npc,
  output rv_isa_pkg::reg_addr_t retire_rd,
  output logic                  retire_wen,
  output rv_isa_pkg::word_t     retire_data
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  word_t   regs [`NUM_REGS];
  logic    held;
  logic    accept;
  credit_t credits;

  ////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////

  assign rs1_rdata = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_rdata = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  assign accept = ex_valid && !stall;

  always_ff @(posedge clock) begin
    if (accept && ex_wen && ex_rd != '0) begin
      regs[ex_rd] <= ex_wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // retire register and credits
  ////////////////////////////////////////////////////////////

  assign stall        = held && (credits == '0);
  assign retire_valid = held && (credits != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      held <= 1'b0;
    end else if (!stall) begin
      held <= ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      retire_pc   <= ex_pc;
      retire_npc  <= ex_npc;
      retire_rd   <= ex_rd;
      retire_wen  <= ex_wen;
      retire_data <= ex_wdata;
    end
  end

  // starts empty, consumer grants.
  always_ff @(posedge clock) begin
    if (reset) begin
      credits <= '0;
    end else begin
      credits <= credits + credit_t'(retire_credit) - credit_t'(retire_valid);
    end
  end

  assign rs_fwd_valid = held && retire_wen;
  assign rs_fwd_rd    = retire_rd;
  assign rs_fwd_data  = retire_data;

  a_credit_limit: assert property (@(posedge clock) disable iff (reset)
    credits <= credit_t'(`RETIRE_CREDITS))
    else $error("retire credits above limit, %0d held", credits);

endmodule
